//--- hdl/bmp_pkg.sv
package bmp_pkg;

  localparam int HEADER_WORDS = 14;
  localparam int GROUP_WORDS  = 3;

  // frame size in bytes, low half in word 0 and high half in word 1
  localparam int SIZE_LO_WORD = 0;
  localparam int SIZE_HI_WORD = 1;

  typedef logic [31:0] word_t;
  typedef logic [23:0] pixel_t;
  typedef logic [1:0]  mode_t;
  typedef logic [31:0] count_t;

  localparam mode_t MODE_THRESHOLD  = 2'd1;
  localparam mode_t MODE_BRIGHTNESS = 2'd2;

  // three words carry four pixels, pixel 0 sits in the top bytes of word 0
  typedef union packed {
    word_t  [0:GROUP_WORDS-1] words;
    pixel_t [0:3]             pixels;
  } pixel_group_u;

endpackage

//--- hdl/word_if.sv
`timescale 1ns/100ps
interface word_if import bmp_pkg::*; ();

  logic       valid;
  word_t      data;
  logic       header;     // word is one of the header words
  logic       last;       // final word of the frame
  mode_t      frame_mode; // settings latched on word 0
  logic [7:0] frame_val;

  modport producer (
    output valid, data, header, last, frame_mode, frame_val
  );

  modport consumer (
    input valid, data, header, last, frame_mode, frame_val
  );

endinterface

//--- hdl/group_if.sv
`timescale 1ns/100ps
interface group_if import bmp_pkg::*; ();

  logic         valid;
  logic         header;     // single header word in word 0
  logic         last;       // item closes the frame
  pixel_group_u group;
  logic [1:0]   count;      // valid words, 1 to 3
  mode_t        frame_mode;
  logic [7:0]   frame_val;

  modport producer (
    output valid, header, last, group, count, frame_mode, frame_val
  );

  modport consumer (
    input valid, header, last, group, count, frame_mode, frame_val
  );

endinterface

//--- hdl/header_parser.sv
`timescale 1ns/100ps
module header_parser import bmp_pkg::*; (
  input  logic       dut_if,
  input  logic       reset_ind,
  input  logic       in_valid,
  input  word_t      in_data,
  input  mode_t      mode,
  input  logic [7:0] proc_val,
  word_if.producer   words
);

  count_t word_cnt;   // index of the incoming word in its frame
  count_t frame_size; // bytes
  count_t last_idx;
  logic   is_last;

  assign last_idx = (frame_size >> 2) - count_t'(1);

  // size is only complete once both size words have gone by
  assign is_last = (word_cnt > SIZE_HI_WORD) && (word_cnt == last_idx);

  always_ff @(posedge dut_if) begin
    if (reset_ind) begin
      word_cnt    <= '0;
      words.valid <= 1'b0;
    end else begin
      words.valid <= in_valid;
      if (in_valid) begin
        if (is_last) begin
          word_cnt <= '0; // re-arm for the next frame
        end else begin
          word_cnt <= word_cnt + count_t'(1);
        end
      end
    end
  end

  always_ff @(posedge dut_if) begin
    if (in_valid) begin
      words.data   <= in_data;
      words.header <= (word_cnt < HEADER_WORDS);
      words.last   <= is_last;
      if (word_cnt == '0) begin
        words.frame_mode <= mode;
        words.frame_val  <= proc_val;
      end
      if (word_cnt == SIZE_LO_WORD) begin
        frame_size[15:0] <= {in_data[7:0], in_data[15:8]};    // little endian
      end
      if (word_cnt == SIZE_HI_WORD) begin
        frame_size[31:16] <= {in_data[23:16], in_data[31:24]};
      end
    end
  end

  // a frame shorter than its own header would never raise last in time
  a_size_min: assert property (@(posedge dut_if) disable iff (reset_ind)
    in_valid && (word_cnt == SIZE_HI_WORD + 1) |-> frame_size >= 4 * HEADER_WORDS);

endmodule

//--- hdl/group_buffer.sv
`timescale 1ns/100ps
module group_buffer import bmp_pkg::*; (
  input logic       dut_if,
  input logic       reset_ind,
  word_if.consumer  words,
  group_if.producer groups
);

  pixel_group_u grp;       // group being filled
  pixel_group_u grp_next;
  logic [1:0]   fill;      // words already in grp
  logic [1:0]   since;     // cycles since the last pixel group, saturates at 3
  logic         held;      // group ready but spacing not met yet
  logic         held_last;
  logic         take_pix;
  logic         complete;
  logic         space_ok;

  assign take_pix = words.valid && !words.header;
  assign complete = take_pix && ((fill == 2'(GROUP_WORDS - 1)) || words.last);
  assign space_ok = (since >= 2'd2); // release now lands 3 cycles after the last one

  always_comb begin
    grp_next = grp;
    grp_next.words[fill] = words.data;
  end

  always_ff @(posedge dut_if) begin
    if (reset_ind) begin
      groups.valid <= 1'b0;
      fill         <= 2'd0;
      since        <= 2'd3;
      held         <= 1'b0;
    end else begin
      groups.valid <= 1'b0;
      if (since != 2'd3) begin
        since <= since + 2'd1;
      end
      if (words.valid && words.header) begin
        groups.valid <= 1'b1;
      end else if (complete) begin
        if (space_ok) begin
          groups.valid <= 1'b1;
          fill         <= 2'd0;
          since        <= 2'd0;
        end else begin
          held <= 1'b1;
          fill <= fill + 2'd1;
        end
      end else if (take_pix) begin
        fill <= fill + 2'd1;
      end else if (held && space_ok) begin
        groups.valid <= 1'b1;
        held         <= 1'b0;
        fill         <= 2'd0;
        since        <= 2'd0;
      end
    end
  end

  always_ff @(posedge dut_if) begin
    if (words.valid) begin
      groups.frame_mode <= words.frame_mode;
      groups.frame_val  <= words.frame_val;
    end
    if (words.valid && words.header) begin
      groups.header <= 1'b1;
      groups.last   <= words.last;
      groups.count  <= 2'd1;
      groups.group  <= {words.data, 64'd0};
    end else if (take_pix) begin
      grp           <= grp_next;
      held_last     <= words.last;
      groups.header <= 1'b0;
      groups.last   <= words.last;
      groups.count  <= fill + 2'd1;
      groups.group  <= grp_next;
    end else if (held) begin
      groups.header <= 1'b0;
      groups.last   <= held_last;
      groups.count  <= fill;
      groups.group  <= grp;
    end
  end

  // the source must leave room for a held group before sending more
  a_no_word_while_held: assert property (@(posedge dut_if) disable iff (reset_ind)
    held |-> !words.valid);

endmodule

//--- hdl/pixel_processor.sv
`timescale 1ns/100ps
module pixel_processor import bmp_pkg::*; (
  input  logic       dut_if,
  input  logic       reset_ind,
  group_if.consumer  groups,
  output logic       out_valid,
  output word_t      out_data,
  output logic       frame_done
);

  pixel_group_u masked;    // input with unused words cleared
  pixel_group_u filtered;
  pixel_group_u res;       // words still to shift out, next one in word 0
  logic [1:0]   left;      // words remaining after the current output
  logic         pend_last;
  logic         out_last;  // current output word ends the frame

  function automatic pixel_t thresh_pixel(input pixel_t p, input logic [7:0] lim);
    logic [9:0] sum;
    sum = 10'(p[23:16]) + 10'(p[15:8]) + 10'(p[7:0]);
    if ((sum / 10'd3) > 10'(lim)) begin
      thresh_pixel = '1;
    end else begin
      thresh_pixel = '0;
    end
  endfunction

  function automatic logic [7:0] shift_byte(input logic [7:0] b, input logic [7:0] off);
    logic signed [9:0] sum;
    sum = $signed({2'b00, b}) + $signed({{2{off[7]}}, off});
    if (sum[9]) begin
      shift_byte = 8'h00; // went below zero
    end else if (sum[8]) begin
      shift_byte = 8'hff;
    end else begin
      shift_byte = sum[7:0];
    end
  endfunction

  always_comb begin
    masked = groups.group;
    for (int i = 0; i < GROUP_WORDS; i++) begin
      if (i >= groups.count) begin
        masked.words[i] = '0;
      end
    end
    filtered = masked;
    if (!groups.header) begin
      if (groups.frame_mode == MODE_THRESHOLD) begin
        for (int p = 0; p < 4; p++) begin
          filtered.pixels[p] = thresh_pixel(masked.pixels[p], groups.frame_val);
        end
      end else if (groups.frame_mode == MODE_BRIGHTNESS) begin
        for (int i = 0; i < GROUP_WORDS; i++) begin
          for (int j = 0; j < 4; j++) begin
            filtered.words[i][8*j +: 8] = shift_byte(masked.words[i][8*j +: 8],
                                                     groups.frame_val);
          end
        end
      end
    end
  end

  always_ff @(posedge dut_if) begin
    if (reset_ind) begin
      out_valid  <= 1'b0;
      out_last   <= 1'b0;
      left       <= 2'd0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= out_valid && out_last;
      if (groups.valid) begin
        out_valid <= 1'b1;
        left      <= groups.count - 2'd1;
        out_last  <= groups.last && (groups.count == 2'd1);
      end else if (left != 2'd0) begin
        out_valid <= 1'b1;
        left      <= left - 2'd1;
        out_last  <= pend_last && (left == 2'd1);
      end else begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end
    end
  end

  always_ff @(posedge dut_if) begin
    if (groups.valid) begin
      out_data  <= filtered.words[0];
      res       <= {filtered.words[1], filtered.words[2], 32'd0};
      pend_last <= groups.last;
    end else if (left != 2'd0) begin
      out_data <= res.words[0];
      res      <= {res.words[1], res.words[2], 32'd0};
    end
  end

  // relies on the spacing kept by the group buffer
  a_no_overlap: assert property (@(posedge dut_if) disable iff (reset_ind)
    groups.valid |-> left == 2'd0);

endmodule

//--- hdl/bmp_filter.sv
`timescale 1ns/100ps
module bmp_filter import bmp_pkg::*; (
  input  logic       dut_if,
  input  logic       reset_ind,
  input  logic       in_valid,
  input  word_t      in_data,
  input  mode_t      mode,
  input  logic [7:0] proc_val,
  output logic       out_valid,
  output word_t      out_data,
  output logic       frame_done
);

  word_if  word_bus ();  // parser to buffer
  group_if group_bus (); // buffer to processor

  header_parser header_parser_inst (
    .dut_if    (dut_if),
    .reset_ind (reset_ind),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .mode      (mode),
    .proc_val  (proc_val),
    .words     (word_bus)
  );

  group_buffer group_buffer_inst (
    .dut_if    (dut_if),
    .reset_ind (reset_ind),
    .words     (word_bus),
    .groups    (group_bus)
  );

  pixel_processor pixel_processor_inst (
    .dut_if     (dut_if),
    .reset_ind  (reset_ind),
    .groups     (group_bus),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .frame_done (frame_done)
  );

endmodule

//--- tests/bmp_filter_tests.svh
`ifndef BMP_FILTER_TESTS_SVH
`define BMP_FILTER_TESTS_SVH

function automatic logic [7:0] brighten(input logic [7:0] b, input logic [7:0] off);
  int v;
  v = int'(b) + int'($signed(off)); // offset is two's complement
  if (v < 0) begin
    return 8'h00;
  end else if (v > 255) begin
    return 8'hff;
  end
  return v[7:0];
endfunction

// group as 96 bits with word 0 and pixel 0 at the top
function automatic logic [95:0] filter_group(input logic [95:0] g, input mode_t m,
                                             input logic [7:0] val);
  logic [95:0] r;
  int          sum;
  r = g;
  if (m == MODE_THRESHOLD) begin
    for (int p = 0; p < 4; p++) begin
      sum = int'(g[95-24*p -: 8]) + int'(g[87-24*p -: 8]) + int'(g[79-24*p -: 8]);
      r[95-24*p -: 24] = (sum / 3 > int'(val)) ? 24'hffffff : 24'h000000;
    end
  end else if (m == MODE_BRIGHTNESS) begin
    for (int b = 0; b < 12; b++) begin
      r[95-8*b -: 8] = brighten(g[95-8*b -: 8], val);
    end
  end
  return r;
endfunction

function automatic void build_frame(input int n_words);
  count_t size;
  word_t  w;
  size = count_t'(4 * n_words);
  frame_q.delete();
  for (int i = 0; i < n_words; i++) begin
    w = next_bits(32);
    if (i == SIZE_LO_WORD) begin
      w[15:0] = {size[7:0], size[15:8]};
    end
    if (i == SIZE_HI_WORD) begin
      w[31:16] = {size[23:16], size[31:24]};
    end
    frame_q.push_back(w);
  end
endfunction

function automatic void model_frame(input mode_t m, input logic [7:0] val);
  logic [95:0] grp;
  int          npix;
  int          cnt;
  for (int i = 0; i < HEADER_WORDS; i++) begin
    exp_q.push_back(frame_q[i]);
    hdr_q.push_back(1'b1);
  end
  npix = frame_q.size() - HEADER_WORDS;
  for (int base = 0; base < npix; base += GROUP_WORDS) begin
    cnt = (npix - base < GROUP_WORDS) ? npix - base : GROUP_WORDS;
    grp = '0; // missing words count as zero
    for (int k = 0; k < cnt; k++) begin
      grp[95-32*k -: 32] = frame_q[HEADER_WORDS + base + k];
    end
    grp = filter_group(grp, m, val);
    for (int k = 0; k < cnt; k++) begin
      exp_q.push_back(grp[95-32*k -: 32]);
      hdr_q.push_back(1'b0);
    end
  end
  frame_len_q.push_back(frame_q.size());
endfunction

task automatic run_frame(input mode_t m, input logic [7:0] val, input bit gaps);
  model_frame(m, val);
  drive_frame(m, val, gaps);
endtask

task automatic header_passthrough();
  start_test("header_passthrough");
  build_frame(SHORT_FRAME);
  run_frame(2'd0, 8'd0, 1'b0);
  close_test(1);
endtask

task automatic brightness_up();
  start_test("brightness_up");
  build_frame(LONG_FRAME);
  run_frame(MODE_BRIGHTNESS, 8'd60, 1'b1);
  close_test(1);
endtask

task automatic brightness_down();
  start_test("brightness_down");
  build_frame(LONG_FRAME);
  run_frame(MODE_BRIGHTNESS, 8'hba, 1'b0); // minus 70
  close_test(1);
endtask

task automatic threshold_and_copy();
  start_test("threshold_and_copy");
  build_frame(LONG_FRAME);
  run_frame(MODE_THRESHOLD, 8'd100, 1'b0);
  build_frame(SHORT_FRAME);
  run_frame(2'd0, 8'(next_bits(8)), 1'b0);
  close_test(2);
endtask

task automatic partial_groups();
  start_test("partial_groups");
  build_frame(ONE_LEFT_FRAME);
  run_frame(MODE_BRIGHTNESS, 8'd30, 1'b0);
  build_frame(TWO_LEFT_FRAME);
  run_frame(MODE_THRESHOLD, 8'd128, 1'b0);
  build_frame(LONG_FRAME);
  run_frame(2'd3, 8'd77, 1'b0);
  close_test(3);
endtask

task automatic reset_mid_frame();
  start_test("reset_mid_frame");
  build_frame(SHORT_FRAME + 10);
  while (frame_q.size() > SHORT_FRAME) begin
    void'(frame_q.pop_back()); // size field still claims the full frame
  end
  drive_frame(MODE_BRIGHTNESS, 8'd40, 1'b0);
  apply_reset(3);
  repeat (10) @(posedge dut_if);
  assert (got_q.size() == 0 && done_q.size() == 0) else begin
    $display("%s: the DUT produced output after reset was asserted", cur_test);
    errors++;
  end
  build_frame(LONG_FRAME);
  run_frame(MODE_BRIGHTNESS, 8'd25, 1'b0);
  close_test(1);
endtask

`endif

//--- tests/bmp_filter_tb.sv
`timescale 1ns/100ps
module bmp_filter_tb import bmp_pkg::*; ();

  localparam int SHORT_FRAME    = 20;             // 6 pixel words
  localparam int LONG_FRAME     = 26;             // 12 pixel words in 4 full groups
  localparam int ONE_LEFT_FRAME = LONG_FRAME + 1; // last group holds one word
  localparam int TWO_LEFT_FRAME = LONG_FRAME + 2;
  localparam int NUM_TESTS      = 6;
  localparam int TOTAL_WORDS    = 3 * SHORT_FRAME + 5 * LONG_FRAME
                                  + ONE_LEFT_FRAME + TWO_LEFT_FRAME;
  localparam int CYCLE_LIMIT    = 2 * (TOTAL_WORDS + 40 * NUM_TESTS);
  localparam int FRAME_GAP      = 2; // a short last group drains in two idle cycles
  localparam int DRAIN_CYCLES   = 4;

  logic       dut_if;
  logic       reset_ind;
  logic       in_valid;
  word_t      in_data;
  mode_t      mode;
  logic [7:0] proc_val;
  logic       out_valid;
  word_t      out_data;
  logic       frame_done;

  logic [15:0] lfsr_state;
  int          cycle = 0;
  string       cur_test;
  int          errors = 0;
  int          err_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  word_t frame_q[$];     // frame being built
  word_t exp_q[$];
  bit    hdr_q[$];       // expected word is a header word
  int    frame_len_q[$];
  word_t got_q[$];
  int    got_cycle_q[$];
  int    in_cycle_q[$];
  int    done_q[$];      // cycles with frame_done high

  bmp_filter bmp_filter_inst (
    .dut_if     (dut_if),
    .reset_ind  (reset_ind),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .mode       (mode),
    .proc_val   (proc_val),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .frame_done (frame_done)
  );

  always #50 dut_if = ~dut_if;

  always @(posedge dut_if) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the DUT never finished the expected frames", cycle);
      $display("Testbench failed");
      $finish;
    end
  end

  // sampled on the falling edge away from the register updates
  always @(negedge dut_if) begin
    if (!reset_ind && in_valid) begin
      in_cycle_q.push_back(cycle);
    end
    if (out_valid) begin
      got_q.push_back(out_data);
      got_cycle_q.push_back(cycle);
    end
    if (frame_done) begin
      done_q.push_back(cycle);
    end
  end

  // galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic int gap_len();
    if (next_bits(2) == 32'd0) begin
      return int'(next_bits(2)); // one word in four waits up to 3 cycles
    end
    return 0;
  endfunction

  task automatic clear_queues();
    exp_q.delete();
    hdr_q.delete();
    frame_len_q.delete();
    got_q.delete();
    got_cycle_q.delete();
    in_cycle_q.delete();
    done_q.delete();
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = errors;
    clear_queues();
  endtask

  task automatic drive_frame(input mode_t m, input logic [7:0] val, input bit gaps);
    int idle;
    for (int i = 0; i < frame_q.size(); i++) begin
      if (gaps && i > 0) begin
        idle = gap_len();
        repeat (idle) begin
          @(posedge dut_if);
          in_valid <= 1'b0;
        end
      end
      @(posedge dut_if);
      in_valid <= 1'b1;
      in_data  <= frame_q[i];
      if (i == 0) begin
        mode     <= m;
        proc_val <= val;
      end
    end
    repeat (FRAME_GAP) begin
      @(posedge dut_if);
      in_valid <= 1'b0;
    end
  endtask

  task automatic apply_reset(input int cycles);
    @(posedge dut_if);
    reset_ind <= 1'b1;
    in_valid  <= 1'b0;
    @(posedge dut_if);
    clear_queues(); // the DUT sees reset from this edge on
    repeat (cycles - 1) @(posedge dut_if);
    reset_ind <= 1'b0;
  endtask

  task automatic check_results();
    int last;
    assert (got_q.size() == exp_q.size()) else begin
      $display("Mismatch in %s: output words expected %0d, actual %0d",
               cur_test, exp_q.size(), got_q.size());
      errors++;
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      assert (got_q[i] === exp_q[i]) else begin
        $display("Mismatch in %s: word %0d expected %08h, actual %08h",
                 cur_test, i, exp_q[i], got_q[i]);
        errors++;
      end
      if (hdr_q[i] && i < in_cycle_q.size()) begin
        assert (got_cycle_q[i] - in_cycle_q[i] == 3) else begin
          $display("Mismatch in %s: header word %0d latency expected 3, actual %0d",
                   cur_test, i, got_cycle_q[i] - in_cycle_q[i]);
          errors++;
        end
      end
    end
    assert (done_q.size() == frame_len_q.size()) else begin
      $display("Mismatch in %s: frame_done pulses expected %0d, actual %0d",
               cur_test, frame_len_q.size(), done_q.size());
      errors++;
    end
    last = -1;
    for (int f = 0; f < frame_len_q.size() && f < done_q.size(); f++) begin
      last += frame_len_q[f];
      if (last < got_cycle_q.size()) begin
        assert (done_q[f] == got_cycle_q[last] + 1) else begin
          $display("Mismatch in %s: frame %0d done cycle expected %0d, actual %0d",
                   cur_test, f, got_cycle_q[last] + 1, done_q[f]);
          errors++;
        end
      end
    end
  endtask

  task automatic close_test(input int frames);
    int n;
    while (done_q.size() < frames) begin
      @(posedge dut_if);
    end
    repeat (DRAIN_CYCLES) @(posedge dut_if); // catch stray words
    check_results();
    n = errors - err_at_start;
    tests_run++;
    if (n == 0) begin
      $display("%-20s ok", cur_test);
    end else begin
      tests_failed++;
      $display("%-20s failed with %0d errors", cur_test, n);
    end
  endtask

  `include "bmp_filter_tests.svh"

  initial begin
    dut_if     = 1'b0;
    reset_ind  = 1'b1;
    in_valid   = 1'b0;
    in_data    = '0;
    mode       = '0;
    proc_val   = '0;
    lfsr_state = 16'd20512;
    repeat (5) @(posedge dut_if);
    reset_ind <= 1'b0;
    header_passthrough();
    brightness_up();
    brightness_down();
    threshold_and_copy();
    partial_groups();
    reset_mid_frame();
    $display("tests run %0d, tests with errors %0d, errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+tests
hdl/bmp_pkg.sv
hdl/word_if.sv
hdl/group_if.sv
hdl/header_parser.sv
hdl/group_buffer.sv
hdl/pixel_processor.sv
hdl/bmp_filter.sv
tests/bmp_filter_tb.sv

//--- run.sh
#!/bin/sh
# build and run the bmp_filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module bmp_filter_tb -f verilog.f

output=$(./obj_dir/Vbmp_filter_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Testbench passed"; then
  exit 0
else
  exit 1
fi
